//--- compile.f
+incdir+include
rtl/mem_pkg.sv
rtl/alloc_pkg.sv
rtl/bv_ram.sv
rtl/ptr_fifo.sv
rtl/rr_arb.sv
rtl/alloc_bv_core.sv
rtl/alloc_bv.sv
testbench/alloc_bv_sva.sv
testbench/alloc_bv_tb.sv

//--- include/alloc_settings.svh
// ----------------------------------------------------------
// Build-time settings for the bit-vector pointer allocator
// ----------------------------------------------------------
`ifndef ALLOC_SETTINGS_SVH
`define ALLOC_SETTINGS_SVH

// Global pointer width
`define PTR_WID 6
// Independent slices, power of two
`define NUM_SLICES 2
// Bitmap bits per RAM row
`define BV_COLS 8
// Per-core queue depths
`define CORE_ALLOC_Q_DEPTH 4
`define CORE_DEALLOC_Q_DEPTH 4

`endif

//--- rtl/alloc_bv.sv
// ----------------------------------------------------------
// Sliced bit-vector pointer allocator, top level
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "alloc_settings.svh"

module alloc_bv (
    input  logic                  clk,
    input  logic                  srst,
    output logic                  init_done,
    input  logic                  alloc_req,
    output logic                  alloc_rdy,
    output logic [`PTR_WID-1:0]   alloc_ptr,
    input  logic                  dealloc_req,
    output logic                  dealloc_rdy,
    input  logic [`PTR_WID-1:0]   dealloc_ptr,
    output alloc_pkg::alloc_mon_t mon
);

    localparam int N        = `NUM_SLICES;
    localparam int SEL_WID  = alloc_pkg::SEL_WID;
    localparam int SPW      = alloc_pkg::SLICE_PTR_WID;
    localparam int CNT_WID  = 4;

    logic [N-1:0]            ram_init_done;
    logic [N-1:0]            core_alloc_req;
    logic [N-1:0]            core_alloc_rdy;
    logic [N-1:0][SPW-1:0]   core_alloc_ptr;
    logic [N-1:0]            core_dealloc_req;
    logic [N-1:0]            core_dealloc_rdy;
    logic [SPW-1:0]          core_dealloc_ptr;
    alloc_pkg::alloc_mon_t   slice_mon [N];

    logic [N-1:0]            grant;
    logic [SEL_WID-1:0]      grant_sel;
    logic                    aq_wr_rdy;
    logic                    dq_wr_rdy;
    logic                    dq_rd_req;
    logic                    dq_rd_rdy;
    logic [`PTR_WID-1:0]     dq_head;
    logic [SEL_WID-1:0]      dq_sel;

    logic [N-1:0][CNT_WID-1:0] dl_cnt;
    logic [N-1:0]              err_flag;
    logic [N-1:0][SPW-1:0]     err_ptr;
    logic [SEL_WID-1:0]        mon_sel;

    // ------------------------------------------------------
    // Slices
    // ------------------------------------------------------
    for (genvar g = 0; g < N; g++) begin : g_slice
        mem_pkg::mem_wr_t    mem_wr;
        mem_pkg::mem_rd_t    mem_rd;
        logic [`BV_COLS-1:0] mem_rd_data;

        bv_ram i_bv_ram (
            .clk, .srst,
            .wr(mem_wr), .rd(mem_rd), .rd_data(mem_rd_data),
            .init_done(ram_init_done[g])
        );

        alloc_bv_core i_alloc_bv_core (
            .clk, .srst,
            .mem_init_done(ram_init_done[g]),
            .alloc_req(core_alloc_req[g]), .alloc_rdy(core_alloc_rdy[g]),
            .alloc_ptr(core_alloc_ptr[g]),
            .dealloc_req(core_dealloc_req[g]), .dealloc_rdy(core_dealloc_rdy[g]),
            .dealloc_ptr(core_dealloc_ptr),
            .mem_wr, .mem_rd, .mem_rd_data,
            .mon(slice_mon[g])
        );
    end

    assign init_done = &ram_init_done;

    // ------------------------------------------------------
    // Allocation merge
    // ------------------------------------------------------
    rr_arb #(.N(N)) i_rr_arb (
        .clk, .srst, .req(core_alloc_rdy), .en(aq_wr_rdy), .grant, .sel(grant_sel)
    );

    assign core_alloc_req = grant & {N{aq_wr_rdy}};

    // Slice index goes into the low bits
    ptr_fifo #(.DATA_WID(`PTR_WID), .DEPTH(N)) i_alloc_q (
        .clk, .srst,
        .wr_req(|core_alloc_rdy), .wr_rdy(aq_wr_rdy),
        .wr_data({core_alloc_ptr[grant_sel], grant_sel}),
        .rd_req(alloc_req), .rd_rdy(alloc_rdy), .rd_data(alloc_ptr)
    );

    // ------------------------------------------------------
    // Deallocation routing
    // ------------------------------------------------------
    ptr_fifo #(.DATA_WID(`PTR_WID), .DEPTH(N)) i_dealloc_q (
        .clk, .srst,
        .wr_req(dealloc_req && init_done), .wr_rdy(dq_wr_rdy), .wr_data(dealloc_ptr),
        .rd_req(dq_rd_req), .rd_rdy(dq_rd_rdy), .rd_data(dq_head)
    );

    assign dealloc_rdy      = dq_wr_rdy && init_done;
    assign dq_sel           = dq_head[SEL_WID-1:0];
    assign core_dealloc_ptr = dq_head[`PTR_WID-1:SEL_WID];
    assign dq_rd_req        = core_dealloc_rdy[dq_sel];

    always_comb begin
        for (int i = 0; i < N; i++)
            core_dealloc_req[i] = dq_rd_rdy && (dq_sel == SEL_WID'(i));
    end

    // ------------------------------------------------------
    // Monitor merge with rotating slice select
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            dl_cnt   <= '0;
            err_flag <= '0;
            mon_sel  <= '0;
            mon      <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                dl_cnt[i] <= dl_cnt[i] + CNT_WID'(slice_mon[i].dealloc)
                           - CNT_WID'(mon_sel == SEL_WID'(i) && dl_cnt[i] != '0);
                // New event wins over the drain
                if (slice_mon[i].dealloc_err)
                    err_flag[i] <= 1'b1;
                else if (mon_sel == SEL_WID'(i))
                    err_flag[i] <= 1'b0;
            end
            mon_sel         <= mon_sel + 1'b1;
            mon.alloc       <= alloc_req && alloc_rdy;
            mon.dealloc     <= dl_cnt[mon_sel] != '0;
            mon.dealloc_err <= err_flag[mon_sel];
            mon.err_ptr     <= {err_ptr[mon_sel], mon_sel};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (slice_mon[i].dealloc_err)
                err_ptr[i] <= slice_mon[i].err_ptr[SPW-1:0];
        end
    end

endmodule

//--- rtl/alloc_bv_core.sv
// ----------------------------------------------------------
// Per-slice allocator core with bitmap scan and free engine
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "alloc_settings.svh"

module alloc_bv_core (
    input  logic                                clk,
    input  logic                                srst,
    input  logic                                mem_init_done,
    input  logic                                alloc_req,
    output logic                                alloc_rdy,
    output logic [alloc_pkg::SLICE_PTR_WID-1:0] alloc_ptr,
    input  logic                                dealloc_req,
    output logic                                dealloc_rdy,
    input  logic [alloc_pkg::SLICE_PTR_WID-1:0] dealloc_ptr,
    output mem_pkg::mem_wr_t                    mem_wr,
    output mem_pkg::mem_rd_t                    mem_rd,
    input  logic [`BV_COLS-1:0]                 mem_rd_data,
    output alloc_pkg::alloc_mon_t               mon
);

    localparam int SPW     = alloc_pkg::SLICE_PTR_WID;
    localparam int ROW_WID = mem_pkg::ROW_WID;
    localparam int COL_WID = alloc_pkg::COL_WID;

    alloc_pkg::core_state_e state;
    alloc_pkg::core_op_e    op;

    logic [ROW_WID-1:0]  row;
    logic [ROW_WID-1:0]  scan_row;
    logic [COL_WID-1:0]  col;
    logic [`BV_COLS-1:0] row_data;
    logic [`BV_COLS-1:0] new_data;
    logic                do_write;
    logic [COL_WID-1:0]  free_col;
    logic                free_found;
    logic                aq_push;
    logic                aq_wr_rdy;
    logic                dq_rd_rdy;
    logic [SPW-1:0]      dq_head;
    logic                start_free;
    logic                start_scan;

    // ------------------------------------------------------
    // Allocation and deallocation queues
    // ------------------------------------------------------
    ptr_fifo #(.DATA_WID(SPW), .DEPTH(`CORE_ALLOC_Q_DEPTH)) i_alloc_q (
        .clk, .srst,
        .wr_req(aq_push), .wr_rdy(aq_wr_rdy), .wr_data({row, col}),
        .rd_req(alloc_req), .rd_rdy(alloc_rdy), .rd_data(alloc_ptr)
    );

    ptr_fifo #(.DATA_WID(SPW), .DEPTH(`CORE_DEALLOC_Q_DEPTH)) i_dealloc_q (
        .clk, .srst,
        .wr_req(dealloc_req), .wr_rdy(dealloc_rdy), .wr_data(dealloc_ptr),
        .rd_req(start_free), .rd_rdy(dq_rd_rdy), .rd_data(dq_head)
    );

    // Queued frees win over a scan step
    assign start_free = (state == alloc_pkg::ST_IDLE) && dq_rd_rdy;
    assign start_scan = (state == alloc_pkg::ST_IDLE) && !dq_rd_rdy && aq_wr_rdy;

    always_comb begin
        mem_rd.en   = start_free || start_scan;
        mem_rd.addr = start_free ? dq_head[SPW-1 -: ROW_WID] : scan_row;
    end

    // Lowest clear bit of the row
    always_comb begin
        free_found = 1'b0;
        free_col   = '0;
        for (int i = `BV_COLS - 1; i >= 0; i--) begin
            if (!row_data[i]) begin
                free_found = 1'b1;
                free_col   = COL_WID'(i);
            end
        end
    end

    // ------------------------------------------------------
    // FSM: idle, read, check, write
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state    <= alloc_pkg::ST_INIT;
            scan_row <= '0;
        end else begin
            case (state)
                alloc_pkg::ST_INIT:  if (mem_init_done) state <= alloc_pkg::ST_IDLE;
                alloc_pkg::ST_IDLE:  if (start_free || start_scan) state <= alloc_pkg::ST_READ;
                alloc_pkg::ST_READ:  state <= alloc_pkg::ST_CHECK;
                alloc_pkg::ST_CHECK: begin
                    // Full row, move the scan on
                    if (op == alloc_pkg::OP_SCAN && !free_found)
                        scan_row <= scan_row + 1'b1;
                    state <= alloc_pkg::ST_WRITE;
                end
                default: state <= alloc_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_free) begin
            op  <= alloc_pkg::OP_FREE;
            row <= dq_head[SPW-1 -: ROW_WID];
            col <= dq_head[COL_WID-1:0];
        end else if (start_scan) begin
            op  <= alloc_pkg::OP_SCAN;
            row <= scan_row;
        end
        if (state == alloc_pkg::ST_READ)
            row_data <= mem_rd_data;
        if (state == alloc_pkg::ST_CHECK) begin
            if (op == alloc_pkg::OP_FREE) begin
                // Bit already clear means a double free
                do_write <= row_data[col];
                new_data <= row_data & ~(`BV_COLS'(1) << col);
            end else begin
                do_write <= free_found;
                col      <= free_col;
                new_data <= row_data | (`BV_COLS'(1) << free_col);
            end
        end
    end

    assign aq_push = (state == alloc_pkg::ST_WRITE) && (op == alloc_pkg::OP_SCAN) && do_write;

    always_comb begin
        mem_wr.en   = (state == alloc_pkg::ST_WRITE) && do_write;
        mem_wr.addr = row;
        mem_wr.data = new_data;

        mon.alloc       = 1'b0;
        mon.dealloc     = (state == alloc_pkg::ST_WRITE) && (op == alloc_pkg::OP_FREE)
                          && do_write;
        mon.dealloc_err = (state == alloc_pkg::ST_WRITE) && (op == alloc_pkg::OP_FREE)
                          && !do_write;
        mon.err_ptr     = `PTR_WID'({row, col});
    end

endmodule

//--- rtl/alloc_pkg.sv
// ----------------------------------------------------------
// Allocator core FSM types, slice widths, monitor struct
// ----------------------------------------------------------
`include "alloc_settings.svh"

package alloc_pkg;
    localparam int SEL_WID       = $clog2(`NUM_SLICES);
    localparam int SLICE_PTR_WID = `PTR_WID - SEL_WID;
    localparam int COL_WID       = $clog2(`BV_COLS);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_READ,
        ST_CHECK,
        ST_WRITE
    } core_state_e;

    // Read-modify-write in flight
    typedef enum logic {
        OP_SCAN,
        OP_FREE
    } core_op_e;

    typedef struct packed {
        logic                alloc;
        logic                dealloc;
        logic                dealloc_err;
        logic [`PTR_WID-1:0] err_ptr;
    } alloc_mon_t;
endpackage

//--- rtl/bv_ram.sv
// ----------------------------------------------------------
// Simple dual-port bitmap RAM with clear-on-reset sequence
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "alloc_settings.svh"

module bv_ram (
    input  logic                clk,
    input  logic                srst,
    input  mem_pkg::mem_wr_t    wr,
    input  mem_pkg::mem_rd_t    rd,
    output logic [`BV_COLS-1:0] rd_data,
    output logic                init_done
);

    logic [`BV_COLS-1:0]         mem [mem_pkg::ROWS];
    logic [mem_pkg::ROW_WID-1:0] clr_addr;
    logic                        clearing;

    // Clear one row per cycle after reset
    always_ff @(posedge clk) begin
        if (srst) begin
            clearing  <= 1'b1;
            clr_addr  <= '0;
            init_done <= 1'b0;
        end else begin
            if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == mem_pkg::ROW_WID'(mem_pkg::ROWS - 1))
                    clearing <= 1'b0;
            end
            init_done <= !clearing;
        end
    end

    // Core requests are ignored while clearing
    always_ff @(posedge clk) begin
        if (clearing)
            mem[clr_addr] <= '0;
        else if (wr.en)
            mem[wr.addr] <= wr.data;
        if (rd.en && !clearing)
            rd_data <= mem[rd.addr];
    end

endmodule

//--- rtl/mem_pkg.sv
// ----------------------------------------------------------
// Bitmap RAM geometry and port request structs
// ----------------------------------------------------------
`include "alloc_settings.svh"

package mem_pkg;
    localparam int ROWS    = (2 ** `PTR_WID) / `NUM_SLICES / `BV_COLS;
    localparam int ROW_WID = $clog2(ROWS);

    typedef struct packed {
        logic                en;
        logic [ROW_WID-1:0]  addr;
        logic [`BV_COLS-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic               en;
        logic [ROW_WID-1:0] addr;
    } mem_rd_t;
endpackage

//--- rtl/ptr_fifo.sv
// ----------------------------------------------------------
// Synchronous FWFT FIFO with req/rdy on both sides
// ----------------------------------------------------------
`timescale 1ns/100ps

module ptr_fifo #(
    parameter int DATA_WID = 8,
    parameter int DEPTH    = 4
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                wr_req,
    output logic                wr_rdy,
    input  logic [DATA_WID-1:0] wr_data,
    input  logic                rd_req,
    output logic                rd_rdy,
    output logic [DATA_WID-1:0] rd_data
);

    localparam int IDX_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_WID-1:0] mem [DEPTH];
    logic [IDX_WID-1:0]  wr_idx;
    logic [IDX_WID-1:0]  rd_idx;
    logic [IDX_WID:0]    count;
    logic                wr_en;
    logic                rd_en;

    assign wr_rdy  = count < (IDX_WID + 1)'(DEPTH);
    assign rd_rdy  = count != '0;
    // Head word is always visible
    assign rd_data = mem[rd_idx];
    assign wr_en   = wr_req && wr_rdy;
    assign rd_en   = rd_req && rd_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_idx <= (wr_idx == IDX_WID'(DEPTH - 1)) ? '0 : wr_idx + 1'b1;
            if (rd_en)
                rd_idx <= (rd_idx == IDX_WID'(DEPTH - 1)) ? '0 : rd_idx + 1'b1;
            count <= count + (IDX_WID + 1)'(wr_en) - (IDX_WID + 1)'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_idx] <= wr_data;
    end

endmodule

//--- rtl/rr_arb.sv
// ----------------------------------------------------------
// Work-conserving round-robin arbiter
// ----------------------------------------------------------
`timescale 1ns/100ps

module rr_arb #(
    parameter int N = 2
) (
    input  logic                                 clk,
    input  logic                                 srst,
    input  logic [N-1:0]                         req,
    input  logic                                 en,
    output logic [N-1:0]                         grant,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] sel
);

    localparam int SEL_WID = (N > 1) ? $clog2(N) : 1;

    logic [SEL_WID-1:0] last;

    // First requester after the last one granted
    always_comb begin
        logic found;
        int   idx;
        found = 1'b0;
        grant = '0;
        sel   = last;
        for (int i = 1; i <= N; i++) begin
            idx = (int'(last) + i) % N;
            if (!found && req[idx]) begin
                found      = 1'b1;
                sel        = SEL_WID'(idx);
                grant[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst)
            last <= SEL_WID'(N - 1);
        else if (en && |req)
            last <= sel;
    end

endmodule

//--- testbench/alloc_bv_sva.sv
// ----------------------------------------------------------
// Concurrent assertions on the allocator top-level
// handshakes and init_done
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "alloc_settings.svh"

module alloc_bv_sva (
    input logic                clk,
    input logic                srst,
    input logic                init_done,
    input logic                alloc_req,
    input logic                alloc_rdy,
    input logic [`PTR_WID-1:0] alloc_ptr
);

    // Offered pointer holds until it is taken
    a_ptr_stable: assert property (@(posedge clk) disable iff (srst)
        alloc_rdy && !alloc_req |=> $stable(alloc_ptr))
        else $error("alloc_ptr changed while offered and not taken");

    a_rdy_after_srst: assert property (@(posedge clk) srst |=> !alloc_rdy)
        else $error("alloc_rdy high on the cycle after srst");

    a_init_held: assert property (@(posedge clk) init_done && !srst |=> init_done)
        else $error("init_done fell outside srst");

endmodule

//--- testbench/alloc_bv_tb.sv
// ----------------------------------------------------------
// Random-stimulus testbench for the sliced pointer allocator
// with a free-list model, timeout and result report
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "alloc_settings.svh"

module alloc_bv_tb;

    localparam int NUM_PTRS   = 1 << `PTR_WID;
    // Several times the total length of all tests
    localparam int MAX_CYCLES = 20000;

    logic                  clk;
    logic                  srst;
    logic                  init_done;
    logic                  alloc_req;
    logic                  alloc_rdy;
    logic [`PTR_WID-1:0]   alloc_ptr;
    logic                  dealloc_req;
    logic                  dealloc_rdy;
    logic [`PTR_WID-1:0]   dealloc_ptr;
    alloc_pkg::alloc_mon_t mon;

    // Free-list model and event counters
    bit held [NUM_PTRS];
    int held_cnt;
    int exp_err_q [$];
    int alloc_hs;
    int free_ok;
    int mon_alloc_cnt;
    int mon_dealloc_cnt;
    int err_seen;
    bit dl_fire;
    bit stall_seen;

    int cycle;
    int test_errs;
    int tests_passed;
    int tests_failed;

    alloc_bv i_alloc_bv (
        .clk, .srst, .init_done,
        .alloc_req, .alloc_rdy, .alloc_ptr,
        .dealloc_req, .dealloc_rdy, .dealloc_ptr,
        .mon
    );

    bind alloc_bv alloc_bv_sva i_alloc_bv_sva (
        .clk(clk), .srst(srst), .init_done(init_done),
        .alloc_req(alloc_req), .alloc_rdy(alloc_rdy), .alloc_ptr(alloc_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle == MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------
    // Checks and model update
    // ------------------------------------------------------
    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            test_errs++;
        end
    endtask

    // One clock edge, outputs sampled as they were before it
    task automatic tick();
        int p;
        @(posedge clk);
        dl_fire = 1'b0;
        if (alloc_req && alloc_rdy) begin
            p = int'(alloc_ptr);
            check_true(!$isunknown(alloc_ptr) && p < NUM_PTRS, "allocated pointer out of range");
            assert (!held[p]) else begin
                $display("Mismatch alloc_ptr: 0x%0h handed out while allocated", p);
                test_errs++;
            end
            if (!held[p])
                held_cnt++;
            held[p] = 1'b1;
            alloc_hs++;
        end
        if (dealloc_req && dealloc_rdy) begin
            p = int'(dealloc_ptr);
            dl_fire = 1'b1;
            if (held[p]) begin
                held[p] = 1'b0;
                held_cnt--;
                free_ok++;
            end else
                exp_err_q.push_back(p);
        end
        if (dealloc_req && !dealloc_rdy)
            stall_seen = 1'b1;
        if (mon.alloc)
            mon_alloc_cnt++;
        if (mon.dealloc)
            mon_dealloc_cnt++;
        if (mon.dealloc_err) begin
            err_seen++;
            if (exp_err_q.size() == 0)
                check_true(1'b0, "dealloc_err pulse without a double free");
            else
                check_eq("mon.err_ptr", int'(mon.err_ptr), exp_err_q.pop_front());
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    function automatic int next_held(input int start);
        for (int i = 0; i < NUM_PTRS; i++) begin
            if (held[(start + i) % NUM_PTRS])
                return (start + i) % NUM_PTRS;
        end
        return 0;
    endfunction

    // ------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------
    task automatic alloc_until_full(input bit gaps, input int limit);
        int n;
        n = 0;
        while (held_cnt < NUM_PTRS && n < limit) begin
            alloc_req <= gaps ? 1'($urandom % 4 != 0) : 1'b1;
            tick();
            n++;
        end
        alloc_req <= 1'b0;
        check_true(held_cnt == NUM_PTRS, "allocation stalled before all pointers were taken");
    endtask

    task automatic expect_no_alloc(input int n);
        repeat (n) begin
            tick();
            check_eq("alloc_rdy", int'(alloc_rdy), 0);
        end
    endtask

    // dealloc_req stays high on return
    task automatic send_free(input int p);
        int c;
        c = 0;
        dealloc_req <= 1'b1;
        dealloc_ptr <= `PTR_WID'(p);
        do begin
            tick();
            c++;
        end while (!dl_fire && c < 200);
        check_true(dl_fire, "free was never accepted");
    endtask

    task automatic free_burst(input int n);
        int p;
        p = 0;
        repeat (n) begin
            p = next_held(p);
            send_free(p);
        end
        dealloc_req <= 1'b0;
    endtask

    // ------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------
    initial begin : stimulus
        int n;
        int p;
        int errs0;
        void'($urandom(32'h3817fcec));
        srst        = 1'b1;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        repeat (10) @(posedge clk);
        srst <= 1'b0;

        // Reset values, then init_done
        tick();
        check_eq("alloc_rdy", int'(alloc_rdy), 0);
        check_eq("dealloc_rdy", int'(dealloc_rdy), 0);
        check_eq("mon", int'(mon), 0);
        check_eq("init_done", int'(init_done), 0);
        n = 0;
        while (!init_done && n < 100) begin
            tick();
            n++;
        end
        check_true(init_done, "init_done did not rise");
        repeat (20) begin
            tick();
            check_eq("init_done", int'(init_done), 1);
        end
        end_test("1 reset and init");

        alloc_until_full(1'b1, 3000);
        expect_no_alloc(300);
        end_test("2 exhaustion");

        // Interleaved traffic, one free in flight at a time
        repeat (600) begin
            alloc_req <= 1'($urandom % 2);
            if (!dealloc_req || dl_fire) begin
                if (held_cnt > 0 && $urandom % 3 == 0) begin
                    dealloc_req <= 1'b1;
                    dealloc_ptr <= `PTR_WID'(next_held($urandom % NUM_PTRS));
                end else
                    dealloc_req <= 1'b0;
            end
            tick();
        end
        alloc_req   <= 1'b0;
        dealloc_req <= 1'b0;
        alloc_until_full(1'b0, 2000);
        stall_seen = 1'b0;
        free_burst(32);
        check_true(stall_seen, "dealloc_rdy never fell during the free burst");
        alloc_until_full(1'b0, 2000);
        end_test("3 mixed traffic");

        // Fill the core queues so the scan pauses, then free twice
        free_burst(16);
        repeat (300) tick();
        p = next_held(0);
        send_free(p);
        errs0 = err_seen;
        send_free(p);
        dealloc_req <= 1'b0;
        n = 0;
        while (err_seen == errs0 && n < 100) begin
            tick();
            n++;
        end
        check_true(err_seen == errs0 + 1, "no dealloc_err pulse within 100 cycles");
        check_eq("mon.dealloc pulses", mon_dealloc_cnt, free_ok);
        alloc_until_full(1'b0, 2000);
        expect_no_alloc(100);
        end_test("4 double free");

        repeat (50) tick();
        check_eq("mon.alloc pulses", mon_alloc_cnt, alloc_hs);
        check_eq("mon.dealloc pulses", mon_dealloc_cnt, free_ok);
        check_eq("pending dealloc_err", exp_err_q.size(), 0);
        end_test("5 monitor counts");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
